/* source/rsp_order_pkg.sv */
/*
 * Shared sizes and payload types for the response-ordering shim.
 * MAX_ACTIVE_REQS must be a power of two so that tag pointers wrap on
 * their own. ALMOST_FULL_RESERVE must cover the one request that may
 * arrive in the cycle almost-full rises.
 */

package rsp_order_pkg;

    // ==============================
    // Sizes
    // ==============================

    // In-flight requests per channel, which is also the tag space
    localparam int MAX_ACTIVE_REQS = 16;
    localparam int REQ_IDX_BITS = $clog2(MAX_ACTIVE_REQS);

    // Requester metadata and data widths
    localparam int MDATA_BITS = 16;
    localparam int DATA_BITS = 32;

    // Slots held back when almost-full is raised
    localparam int ALMOST_FULL_RESERVE = 2;

    // ==============================
    // Types
    // ==============================

    // Tag sent to the fabric in place of the requester's metadata
    typedef logic [REQ_IDX_BITS-1:0] t_req_idx;

    // Free-slot counter, one bit wider so that it can hold MAX_ACTIVE_REQS
    typedef logic [REQ_IDX_BITS:0] t_slot_cnt;

    typedef logic [MDATA_BITS-1:0] t_mdata;
    typedef logic [DATA_BITS-1:0] t_data;

endpackage

/* source/slot_port_if.sv */
/*
 * One write port and one read port of a slot memory.
 * rd_data follows rd_idx by one cycle; a read of a slot written in the
 * same cycle returns the old content.
 */

`timescale 1ns/1ns

interface slot_port_if
    import rsp_order_pkg::*;
#(
    parameter type t_payload = logic
)
();

    // Write side
    logic wr_en;
    t_req_idx wr_idx;
    t_payload wr_data;

    // Read side
    t_req_idx rd_idx;
    t_payload rd_data;

    // The block that owns the slots picks indices and supplies data
    modport owner (output wr_en, output wr_idx, output wr_data, output rd_idx,
                   input rd_data);

    // The storage itself only returns read data
    modport ram (input wr_en, input wr_idx, input wr_data, input rd_idx,
                 output rd_data);

endinterface

/* source/slot_ram.sv */
/*
 * Indexed slot storage with one synchronous write and a registered read.
 * Contents are not cleared by reset, so a slot must be written before
 * it is read back.
 */

`timescale 1ns/1ns

module slot_ram
    import rsp_order_pkg::*;
#(
    parameter type t_payload = logic
)
(
    input logic clk,
    slot_port_if.ram port
);

    // One entry per tag
    t_payload mem [MAX_ACTIVE_REQS];

    // Write takes effect at the clock edge
    always_ff @(posedge clk)
    begin
        if (port.wr_en)
        begin
            mem[port.wr_idx] <= port.wr_data;
        end
    end

    // Registered read
    // A slot written in the same cycle still returns its old content here,
    // since the write above has not landed yet
    always_ff @(posedge clk)
    begin
        port.rd_data <= mem[port.rd_idx];
    end

endmodule

/* source/write_mdata_heap.sv */
/*
 * Tag heap for the write channel. Hands out free tags, parks the
 * requester metadata under each tag, and restores it two cycles after the
 * fabric answers. The requester must stop allocating while almost_full
 * is high, and the fabric must only answer tags that are outstanding.
 */

`timescale 1ns/1ns

module write_mdata_heap
    import rsp_order_pkg::*;
(
    input logic clk,
    input logic reset,

    // Allocation by a new write request
    input logic alloc,
    input t_mdata alloc_mdata,
    output t_req_idx alloc_idx,
    output logic almost_full,

    // Response from the fabric, by tag
    input logic rsp_valid,
    input t_req_idx rsp_idx,
    output logic restored_valid,
    output t_mdata restored_mdata
);

    // ==============================
    // Free list
    // ==============================

    // Circular list of free tags
    // Allocation pops from the head and a freed tag is pushed at the tail
    t_req_idx free_list [MAX_ACTIVE_REQS];
    t_req_idx fl_head;
    t_req_idx fl_tail;
    t_slot_cnt free_cnt;

    assign alloc_idx = free_list[fl_head];

    // Raised while only the reserve is left
    assign almost_full = (free_cnt <= t_slot_cnt'(ALMOST_FULL_RESERVE));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Every tag starts out free, in order
            for (int i = 0; i < MAX_ACTIVE_REQS; i++)
            begin
                free_list[i] <= t_req_idx'(i);
            end
            fl_head <= '0;
            fl_tail <= '0;
            free_cnt <= t_slot_cnt'(MAX_ACTIVE_REQS);
        end
        else
        begin
            if (alloc)
            begin
                fl_head <= fl_head + 1'b1;
            end

            // The freed tag lands behind every other free tag, so it is
            // not handed out again in the same cycle
            if (rsp_valid)
            begin
                free_list[fl_tail] <= rsp_idx;
                fl_tail <= fl_tail + 1'b1;
            end

            case ({alloc, rsp_valid})
                2'b10: free_cnt <= free_cnt - 1'b1;
                2'b01: free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    // ==============================
    // Metadata storage
    // ==============================

    slot_port_if #(.t_payload(t_mdata)) mdata_port ();

    // Metadata is parked under the tag it was given
    assign mdata_port.wr_en = alloc;
    assign mdata_port.wr_idx = alloc_idx;
    assign mdata_port.wr_data = alloc_mdata;

    // Look up by the tag the fabric returned
    assign mdata_port.rd_idx = rsp_idx;

    slot_ram #(.t_payload(t_mdata)) mdata_ram
    (
        .clk,
        .port(mdata_port.ram)
    );

    // RAM data shows up one cycle after the response, the output register
    // adds the second cycle
    logic rsp_valid_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid_q <= 1'b0;
            restored_valid <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= rsp_valid;
            restored_valid <= rsp_valid_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rsp_valid_q)
        begin
            restored_mdata <= mdata_port.rd_data;
        end
    end

endmodule

/* source/read_reorder_buffer.sv */
/*
 * Reorder buffer for the read channel. Slots are allocated in request
 * order, filled by fabric responses in any order, and released in
 * request order at most one per cycle. Output follows a dequeue by two
 * cycles and has no back-pressure.
 */

`timescale 1ns/1ns

module read_reorder_buffer
    import rsp_order_pkg::*;
(
    input logic clk,
    input logic reset,

    // Allocation by a new read request
    input logic alloc,
    input t_mdata alloc_mdata,
    output t_req_idx alloc_idx,
    output logic almost_full,

    // Fill from the fabric, by tag
    input logic fill_valid,
    input t_req_idx fill_idx,
    input t_data fill_data,

    // In-order output toward the requester
    output logic out_valid,
    output t_mdata out_mdata,
    output t_data out_data
);

    // ==============================
    // Ring control
    // ==============================

    // Tail is the next slot to allocate and head the oldest one in use
    t_req_idx rob_head;
    t_req_idx rob_tail;
    t_slot_cnt free_cnt;

    // Set when a slot's response has arrived
    logic [MAX_ACTIVE_REQS-1:0] filled;

    logic deq;

    // The tag handed to the fabric is the slot index itself
    assign alloc_idx = rob_tail;

    assign almost_full = (free_cnt <= t_slot_cnt'(ALMOST_FULL_RESERVE));

    // The oldest slot leaves as soon as its data is in.
    // A slot that is not in use always has its filled bit clear
    assign deq = filled[rob_head];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rob_head <= '0;
            rob_tail <= '0;
            free_cnt <= t_slot_cnt'(MAX_ACTIVE_REQS);
            filled <= '0;
        end
        else
        begin
            if (alloc)
            begin
                rob_tail <= rob_tail + 1'b1;
            end

            if (deq)
            begin
                rob_head <= rob_head + 1'b1;
                filled[rob_head] <= 1'b0;
            end

            // A fill never names the slot being dequeued, since that slot
            // has already been filled
            if (fill_valid)
            begin
                filled[fill_idx] <= 1'b1;
            end

            case ({alloc, deq})
                2'b10: free_cnt <= free_cnt - 1'b1;
                2'b01: free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    // ==============================
    // Slot storage
    // ==============================

    slot_port_if #(.t_payload(t_mdata)) mdata_port ();
    slot_port_if #(.t_payload(t_data)) data_port ();

    // Metadata is written at allocation
    assign mdata_port.wr_en = alloc;
    assign mdata_port.wr_idx = rob_tail;
    assign mdata_port.wr_data = alloc_mdata;
    assign mdata_port.rd_idx = rob_head;

    // Data is written when the fabric answers
    assign data_port.wr_en = fill_valid;
    assign data_port.wr_idx = fill_idx;
    assign data_port.wr_data = fill_data;
    assign data_port.rd_idx = rob_head;

    slot_ram #(.t_payload(t_mdata)) mdata_ram
    (
        .clk,
        .port(mdata_port.ram)
    );

    slot_ram #(.t_payload(t_data)) data_ram
    (
        .clk,
        .port(data_port.ram)
    );

    // ==============================
    // Output pipeline
    // ==============================

    // One stage for the RAM read and one for the output register.
    // A new dequeue may start every cycle, so up to two are in flight
    logic deq_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            deq_q <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            deq_q <= deq;
            out_valid <= deq_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (deq_q)
        begin
            out_mdata <= mdata_port.rd_data;
            out_data <= data_port.rd_data;
        end
    end

endmodule

/* source/rsp_order_top.sv */
/*
 * Response-ordering shim between a requester and an out-of-order fabric.
 * Requests pass through in the same cycle with a tag in place of their
 * metadata. Read responses return in request order, write responses in
 * fabric order two cycles later. The requester must honor almost-full.
 */

`timescale 1ns/1ns

module rsp_order_top
    import rsp_order_pkg::*;
(
    input logic clk,
    input logic reset,

    // Requester read channel
    input logic afu_rd_req_valid,
    input t_mdata afu_rd_req_mdata,
    output logic afu_rd_almost_full,
    output logic afu_rd_rsp_valid,
    output t_mdata afu_rd_rsp_mdata,
    output t_data afu_rd_rsp_data,

    // Requester write channel
    input logic afu_wr_req_valid,
    input t_mdata afu_wr_req_mdata,
    input t_data afu_wr_req_data,
    output logic afu_wr_almost_full,
    output logic afu_wr_rsp_valid,
    output t_mdata afu_wr_rsp_mdata,

    // Fabric read channel
    output logic fiu_rd_req_valid,
    output t_req_idx fiu_rd_req_tag,
    input logic fiu_rd_almost_full,
    input logic fiu_rd_rsp_valid,
    input t_req_idx fiu_rd_rsp_tag,
    input t_data fiu_rd_rsp_data,

    // Fabric write channel
    output logic fiu_wr_req_valid,
    output t_req_idx fiu_wr_req_tag,
    output t_data fiu_wr_req_data,
    input logic fiu_wr_almost_full,
    input logic fiu_wr_rsp_valid,
    input t_req_idx fiu_wr_rsp_tag
);

    logic rob_almost_full;
    logic heap_almost_full;

    // ==============================
    // Read channel
    // ==============================

    // Requests go straight out, tagged with their reorder slot
    assign fiu_rd_req_valid = afu_rd_req_valid;
    assign afu_rd_almost_full = fiu_rd_almost_full | rob_almost_full;

    read_reorder_buffer rd_rob
    (
        .clk,
        .reset,
        .alloc(afu_rd_req_valid),
        .alloc_mdata(afu_rd_req_mdata),
        .alloc_idx(fiu_rd_req_tag),
        .almost_full(rob_almost_full),
        .fill_valid(fiu_rd_rsp_valid),
        .fill_idx(fiu_rd_rsp_tag),
        .fill_data(fiu_rd_rsp_data),
        .out_valid(afu_rd_rsp_valid),
        .out_mdata(afu_rd_rsp_mdata),
        .out_data(afu_rd_rsp_data)
    );

    // ==============================
    // Write channel
    // ==============================

    // Data passes untouched, the metadata waits in the heap
    assign fiu_wr_req_valid = afu_wr_req_valid;
    assign fiu_wr_req_data = afu_wr_req_data;
    assign afu_wr_almost_full = fiu_wr_almost_full | heap_almost_full;

    write_mdata_heap wr_heap
    (
        .clk,
        .reset,
        .alloc(afu_wr_req_valid),
        .alloc_mdata(afu_wr_req_mdata),
        .alloc_idx(fiu_wr_req_tag),
        .almost_full(heap_almost_full),
        .rsp_valid(fiu_wr_rsp_valid),
        .rsp_idx(fiu_wr_rsp_tag),
        .restored_valid(afu_wr_rsp_valid),
        .restored_mdata(afu_wr_rsp_mdata)
    );

endmodule

/* verification/tb_clock_gen.sv */
/*
 * Clock and reset for the testbench. 100 ns period, reset held high
 * for four rising edges and released shortly after the fourth one.
 */

`timescale 1ns/1ns

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    localparam time HALF_PERIOD = 50;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release follows the same drive delay as the rest of the stimulus
    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
    end

endmodule

/* verification/rsp_order_checker.sv */
/*
 * Watches the shim on its ports and compares against a reference model
 * built from the request and fabric traffic. Samples on the falling edge,
 * when every input and output is settled. Read tags are taken as the
 * reorder slot, so a tag is busy until that slot has been dequeued.
 */

`timescale 1ns/1ns

module rsp_order_checker
    import rsp_order_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic afu_rd_req_valid,
    input t_mdata afu_rd_req_mdata,
    input logic afu_rd_almost_full,
    input logic afu_rd_rsp_valid,
    input t_mdata afu_rd_rsp_mdata,
    input t_data afu_rd_rsp_data,
    input logic afu_wr_req_valid,
    input t_mdata afu_wr_req_mdata,
    input t_data afu_wr_req_data,
    input logic afu_wr_almost_full,
    input logic afu_wr_rsp_valid,
    input t_mdata afu_wr_rsp_mdata,
    input logic fiu_rd_req_valid,
    input t_req_idx fiu_rd_req_tag,
    input logic fiu_rd_almost_full,
    input logic fiu_rd_rsp_valid,
    input t_req_idx fiu_rd_rsp_tag,
    input t_data fiu_rd_rsp_data,
    input logic fiu_wr_req_valid,
    input t_req_idx fiu_wr_req_tag,
    input t_data fiu_wr_req_data,
    input logic fiu_wr_almost_full,
    input logic fiu_wr_rsp_valid,
    input t_req_idx fiu_wr_rsp_tag,
    output logic idle,
    output int value_errors,
    output int protocol_errors
);

    // Reads in request order. Entries below rd_deq have left the reorder
    // buffer and wait for their output cycle in rd_out_due
    t_mdata rd_mdata [$];
    t_data rd_data [$];
    t_req_idx rd_tag [$];
    bit rd_filled [$];
    int rd_out_due [$];
    int rd_deq;

    // Outstanding writes, and restored metadata waiting for its cycle
    t_req_idx wr_tag [$];
    t_mdata wr_mdata [$];
    t_mdata wr_exp_mdata [$];
    int wr_exp_due [$];

    int cyc;
    bit reset_q;
    bit rd_af_seen;
    bit wr_af_seen;

    // The DUT holds no defined state before its first rising edge
    bit clk_started;

    initial
    begin
        value_errors = 0;
        protocol_errors = 0;
        idle = 1'b1;
        cyc = 0;
        rd_deq = 0;
    end

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("error %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
        value_errors++;
    endtask

    task automatic protocol_failure(input string msg);
        $display("At %0t: %s", $time, msg);
        protocol_errors++;
    endtask

    task automatic drop_read_front();
        void'(rd_mdata.pop_front());
        void'(rd_data.pop_front());
        void'(rd_tag.pop_front());
        void'(rd_filled.pop_front());
        void'(rd_out_due.pop_front());
        rd_deq--;
    endtask

    // ==============================
    // Read channel
    // ==============================

    task automatic track_reads();
        int found;
        // Output side first, since it only touches dequeued entries
        if (rd_out_due.size() > 0 && rd_out_due[0] < cyc)
        begin
            protocol_failure("a read response did not appear two cycles after its dequeue");
            drop_read_front();
        end
        if (afu_rd_rsp_valid)
        begin
            if (rd_out_due.size() == 0 || rd_out_due[0] != cyc)
            begin
                protocol_failure("a read response appeared at a cycle with none due");
            end
            else
            begin
                if (afu_rd_rsp_mdata !== rd_mdata[0])
                begin
                    value_mismatch("afu_rd_rsp_mdata", rd_mdata[0], afu_rd_rsp_mdata);
                end
                if (afu_rd_rsp_data !== rd_data[0])
                begin
                    value_mismatch("afu_rd_rsp_data", rd_data[0], afu_rd_rsp_data);
                end
                drop_read_front();
            end
        end
        if (fiu_rd_req_valid !== afu_rd_req_valid)
        begin
            value_mismatch("fiu_rd_req_valid", afu_rd_req_valid, fiu_rd_req_valid);
        end
        // A new tag must not name a slot still held in the reorder buffer
        if (afu_rd_req_valid)
        begin
            for (int i = rd_deq; i < rd_tag.size(); i++)
            begin
                if (rd_tag[i] == fiu_rd_req_tag)
                begin
                    protocol_failure($sformatf("read tag %0d reissued while busy", fiu_rd_req_tag));
                end
            end
            rd_mdata.push_back(afu_rd_req_mdata);
            rd_data.push_back('0);
            rd_tag.push_back(fiu_rd_req_tag);
            rd_filled.push_back(1'b0);
        end
        // Oldest slot leaves once filled, one per cycle, and reaches the
        // requester two cycles later
        if (rd_deq < rd_tag.size() && rd_filled[rd_deq])
        begin
            rd_out_due.push_back(cyc + 2);
            rd_deq++;
        end
        // Fill after the dequeue so that a fill counts from the next cycle
        if (fiu_rd_rsp_valid)
        begin
            found = -1;
            for (int i = rd_deq; i < rd_tag.size(); i++)
            begin
                if (found < 0 && rd_tag[i] == fiu_rd_rsp_tag && !rd_filled[i])
                begin
                    found = i;
                end
            end
            if (found < 0)
            begin
                protocol_failure($sformatf("read response for tag %0d, which is not outstanding",
                                           fiu_rd_rsp_tag));
            end
            else
            begin
                rd_filled[found] = 1'b1;
                rd_data[found] = fiu_rd_rsp_data;
            end
        end
    endtask

    // ==============================
    // Write channel
    // ==============================

    task automatic track_writes();
        int found;
        if (wr_exp_due.size() > 0 && wr_exp_due[0] < cyc)
        begin
            protocol_failure("a write response did not appear two cycles after the fabric");
            void'(wr_exp_due.pop_front());
            void'(wr_exp_mdata.pop_front());
        end
        if (afu_wr_rsp_valid)
        begin
            if (wr_exp_due.size() == 0 || wr_exp_due[0] != cyc)
            begin
                protocol_failure("a write response appeared at a cycle with none due");
            end
            else
            begin
                if (afu_wr_rsp_mdata !== wr_exp_mdata[0])
                begin
                    value_mismatch("afu_wr_rsp_mdata", wr_exp_mdata[0], afu_wr_rsp_mdata);
                end
                void'(wr_exp_due.pop_front());
                void'(wr_exp_mdata.pop_front());
            end
        end
        if (fiu_wr_req_valid !== afu_wr_req_valid)
        begin
            value_mismatch("fiu_wr_req_valid", afu_wr_req_valid, fiu_wr_req_valid);
        end
        // Checked before this cycle's response frees its tag, since a freed
        // tag must not come back in the same cycle
        if (afu_wr_req_valid)
        begin
            if (fiu_wr_req_data !== afu_wr_req_data)
            begin
                value_mismatch("fiu_wr_req_data", afu_wr_req_data, fiu_wr_req_data);
            end
            foreach (wr_tag[i])
            begin
                if (wr_tag[i] == fiu_wr_req_tag)
                begin
                    protocol_failure($sformatf("write tag %0d reissued while busy", fiu_wr_req_tag));
                end
            end
            wr_tag.push_back(fiu_wr_req_tag);
            wr_mdata.push_back(afu_wr_req_mdata);
        end
        if (fiu_wr_rsp_valid)
        begin
            found = -1;
            foreach (wr_tag[i])
            begin
                if (found < 0 && wr_tag[i] == fiu_wr_rsp_tag)
                begin
                    found = i;
                end
            end
            if (found < 0)
            begin
                protocol_failure($sformatf("write response for tag %0d, which is not outstanding",
                                           fiu_wr_rsp_tag));
            end
            else
            begin
                wr_exp_mdata.push_back(wr_mdata[found]);
                wr_exp_due.push_back(cyc + 2);
                wr_tag.delete(found);
                wr_mdata.delete(found);
            end
        end
    endtask

    // ==============================
    // Per-cycle comparison
    // ==============================

    always @(posedge clk)
    begin
        clk_started <= 1'b1;
    end

    always @(negedge clk)
    begin
        logic exp_rd_af;
        logic exp_wr_af;
        if (clk_started)
        begin
            cyc++;
            if (reset || reset_q)
            begin
                // Nothing may be valid or full around reset
                if (afu_rd_rsp_valid !== 1'b0)
                begin
                    value_mismatch("afu_rd_rsp_valid", 0, afu_rd_rsp_valid);
                end
                if (afu_wr_rsp_valid !== 1'b0)
                begin
                    value_mismatch("afu_wr_rsp_valid", 0, afu_wr_rsp_valid);
                end
                if (afu_rd_almost_full !== 1'b0)
                begin
                    value_mismatch("afu_rd_almost_full", 0, afu_rd_almost_full);
                end
                if (afu_wr_almost_full !== 1'b0)
                begin
                    value_mismatch("afu_wr_almost_full", 0, afu_wr_almost_full);
                end
            end
            if (reset)
            begin
                rd_mdata.delete();
                rd_data.delete();
                rd_tag.delete();
                rd_filled.delete();
                rd_out_due.delete();
                rd_deq = 0;
                wr_tag.delete();
                wr_mdata.delete();
                wr_exp_mdata.delete();
                wr_exp_due.delete();
            end
            else
            begin
                // Occupancy before this cycle's events matches what the
                // counters in the DUT hold during this cycle
                exp_rd_af = fiu_rd_almost_full ||
                            (MAX_ACTIVE_REQS - (rd_tag.size() - rd_deq) <= ALMOST_FULL_RESERVE);
                exp_wr_af = fiu_wr_almost_full ||
                            (MAX_ACTIVE_REQS - wr_tag.size() <= ALMOST_FULL_RESERVE);
                if (afu_rd_almost_full !== exp_rd_af)
                begin
                    value_mismatch("afu_rd_almost_full", exp_rd_af, afu_rd_almost_full);
                end
                if (afu_wr_almost_full !== exp_wr_af)
                begin
                    value_mismatch("afu_wr_almost_full", exp_wr_af, afu_wr_almost_full);
                end
                rd_af_seen |= (afu_rd_almost_full === 1'b1);
                wr_af_seen |= (afu_wr_almost_full === 1'b1);
                track_reads();
                track_writes();
            end
            reset_q = reset;
            idle = (rd_tag.size() == 0) && (wr_tag.size() == 0) && (wr_exp_due.size() == 0);
        end
    end

    // Called once the stimulus has drained
    task automatic check_end();
        if (!idle)
        begin
            protocol_failure("requests were still outstanding when the run ended");
        end
        if (!rd_af_seen)
        begin
            protocol_failure("read almost-full never rose during the run");
        end
        if (!wr_af_seen)
        begin
            protocol_failure("write almost-full never rose during the run");
        end
    endtask

endmodule

/* verification/rsp_order_tb.sv */
/*
 * Testbench top for the response-ordering shim. Requests come from the
 * stimulus file one per cycle, in file order, and wait while their
 * channel is almost full. The fabric model answers each tag after the
 * hold count of its line and never raises its own almost-full.
 */

`timescale 1ns/1ns

module rsp_order_tb
    import rsp_order_pkg::*;
();

    localparam int DRIVE_DELAY = 10;
    localparam int unsigned RAND_SEED = 32'hb979_9d67;

    logic clk;
    logic reset;
    logic afu_rd_req_valid;
    t_mdata afu_rd_req_mdata;
    logic afu_rd_almost_full;
    logic afu_rd_rsp_valid;
    t_mdata afu_rd_rsp_mdata;
    t_data afu_rd_rsp_data;
    logic afu_wr_req_valid;
    t_mdata afu_wr_req_mdata;
    t_data afu_wr_req_data;
    logic afu_wr_almost_full;
    logic afu_wr_rsp_valid;
    t_mdata afu_wr_rsp_mdata;
    logic fiu_rd_req_valid;
    t_req_idx fiu_rd_req_tag;
    logic fiu_rd_almost_full;
    logic fiu_rd_rsp_valid;
    t_req_idx fiu_rd_rsp_tag;
    t_data fiu_rd_rsp_data;
    logic fiu_wr_req_valid;
    t_req_idx fiu_wr_req_tag;
    t_data fiu_wr_req_data;
    logic fiu_wr_almost_full;
    logic fiu_wr_rsp_valid;
    t_req_idx fiu_wr_rsp_tag;
    logic idle;
    int value_errors;
    int protocol_errors;

    // Stimulus lines, filled from the data file
    byte stim_op [$];
    t_mdata stim_mdata [$];
    t_data stim_data [$];
    int stim_hold [$];
    bit stim_loaded;

    // Fabric model state with one entry per tag and channel
    bit rd_busy [MAX_ACTIVE_REQS];
    int rd_due [MAX_ACTIVE_REQS];
    t_data rd_ret [MAX_ACTIVE_REQS];
    bit wr_busy [MAX_ACTIVE_REQS];
    int wr_due [MAX_ACTIVE_REQS];
    int cyc;

    tb_clock_gen i_clock_gen (.clk, .reset);

    rsp_order_top i_dut (.*);

    rsp_order_checker i_checker (.*);

    // ==============================
    // Stimulus file
    // ==============================

    task automatic load_stimulus();
        int fd;
        int n;
        string line;
        byte op;
        t_mdata md;
        t_data dt;
        int hold;
        fd = $fopen("verification/rsp_order_stim.txt", "r");
        if (fd == 0)
        begin
            i_checker.protocol_failure("the stimulus file could not be opened");
            return;
        end
        while ($fgets(line, fd) > 0)
        begin
            // Blank lines and comment lines carry no request
            if (line.len() < 2 || line.substr(0, 1) == "//")
            begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %d", op, md, dt, hold);
            if (n != 4 || (op != "R" && op != "W"))
            begin
                i_checker.protocol_failure({"unreadable stimulus line: ", line});
                continue;
            end
            stim_op.push_back(op);
            stim_mdata.push_back(md);
            stim_data.push_back(dt);
            stim_hold.push_back(hold);
        end
        $fclose(fd);
    endtask

    // ==============================
    // Fabric model
    // ==============================

    function automatic bit fabric_busy();
        fabric_busy = 1'b0;
        for (int t = 0; t < MAX_ACTIVE_REQS; t++)
        begin
            fabric_busy |= rd_busy[t] | wr_busy[t];
        end
    endfunction

    // At most one response per channel and cycle. Among tags whose hold
    // has run out, a random one goes first
    task automatic fabric_respond();
        int ready [$];
        int pick;
        fiu_rd_rsp_valid = 1'b0;
        fiu_wr_rsp_valid = 1'b0;
        for (int t = 0; t < MAX_ACTIVE_REQS; t++)
        begin
            if (rd_busy[t] && cyc >= rd_due[t])
            begin
                ready.push_back(t);
            end
        end
        if (ready.size() > 0)
        begin
            pick = ready[$urandom % ready.size()];
            fiu_rd_rsp_valid = 1'b1;
            fiu_rd_rsp_tag = t_req_idx'(pick);
            fiu_rd_rsp_data = rd_ret[pick];
            rd_busy[pick] = 1'b0;
        end
        ready.delete();
        for (int t = 0; t < MAX_ACTIVE_REQS; t++)
        begin
            if (wr_busy[t] && cyc >= wr_due[t])
            begin
                ready.push_back(t);
            end
        end
        if (ready.size() > 0)
        begin
            pick = ready[$urandom % ready.size()];
            fiu_wr_rsp_valid = 1'b1;
            fiu_wr_rsp_tag = t_req_idx'(pick);
            wr_busy[pick] = 1'b0;
        end
    endtask

    // Drives one stimulus line if its channel has room. The fabric model
    // learns the tag from the request, as a real fabric would
    task automatic try_issue(input int idx, output bit issued);
        t_req_idx tag;
        issued = 1'b0;
        if (stim_op[idx] == "R" && !afu_rd_almost_full)
        begin
            tag = fiu_rd_req_tag;
            afu_rd_req_valid = 1'b1;
            afu_rd_req_mdata = stim_mdata[idx];
            rd_busy[tag] = 1'b1;
            rd_due[tag] = cyc + stim_hold[idx];
            rd_ret[tag] = stim_data[idx];
            issued = 1'b1;
        end
        else if (stim_op[idx] == "W" && !afu_wr_almost_full)
        begin
            tag = fiu_wr_req_tag;
            afu_wr_req_valid = 1'b1;
            afu_wr_req_mdata = stim_mdata[idx];
            afu_wr_req_data = stim_data[idx];
            wr_busy[tag] = 1'b1;
            wr_due[tag] = cyc + stim_hold[idx];
            issued = 1'b1;
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial
    begin
        int line_idx;
        bit issued;
        int unsigned seed_ret;
        afu_rd_req_valid = 1'b0;
        afu_rd_req_mdata = '0;
        afu_wr_req_valid = 1'b0;
        afu_wr_req_mdata = '0;
        afu_wr_req_data = '0;
        fiu_rd_almost_full = 1'b0;
        fiu_rd_rsp_valid = 1'b0;
        fiu_rd_rsp_tag = '0;
        fiu_rd_rsp_data = '0;
        fiu_wr_almost_full = 1'b0;
        fiu_wr_rsp_valid = 1'b0;
        fiu_wr_rsp_tag = '0;
        seed_ret = $urandom(RAND_SEED);
        cyc = 0;
        line_idx = 0;
        load_stimulus();
        stim_loaded = 1'b1;
        @(negedge reset);
        // Runs until every line is issued and every response has come back
        while (line_idx < stim_op.size() || fabric_busy() || !idle)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            cyc++;
            afu_rd_req_valid = 1'b0;
            afu_wr_req_valid = 1'b0;
            fabric_respond();
            if (line_idx < stim_op.size())
            begin
                try_issue(line_idx, issued);
                if (issued)
                begin
                    line_idx++;
                end
            end
        end
        repeat (4) @(posedge clk);
        i_checker.check_end();
        $display("Error count: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial
    begin
        int limit;
        wait (stim_loaded);
        limit = 20 * stim_op.size() + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Error count: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("Regression failed");
        $finish;
    end

endmodule

/* rsp_order.f */
source/rsp_order_pkg.sv
source/slot_port_if.sv
source/slot_ram.sv
source/write_mdata_heap.sv
source/read_reorder_buffer.sv
source/rsp_order_top.sv
verification/tb_clock_gen.sv
verification/rsp_order_checker.sv
verification/rsp_order_tb.sv

/* verification/rsp_order_stim.txt */
// Columns: op (R read, W write), metadata hex, data hex, fabric hold in cycles
// Mixed traffic first, then a long-hold burst per channel to reach almost-full
R 0101 a5a50001 6
W 0201 5a5a0002 2
R 0102 a5a50003 1
W 0202 5a5a0004 5
R 0103 a5a50005 3
W 0203 5a5a0006 0
R 0110 c0de0010 30
R 0111 c0de0111 44
R 0112 c0de0212 35
R 0113 c0de0313 31
R 0114 c0de0414 40
R 0115 c0de0515 33
R 0116 c0de0616 45
R 0117 c0de0717 38
R 0118 c0de0818 30
R 0119 c0de0919 41
R 011a c0de0a1a 36
R 011b c0de0b1b 32
R 011c c0de0c1c 43
R 011d c0de0d1d 39
R 011e c0de0e1e 34
W 0210 feed0010 42
W 0211 feed0111 31
W 0212 feed0212 37
W 0213 feed0313 30
W 0214 feed0414 45
W 0215 feed0515 33
W 0216 feed0616 40
W 0217 feed0717 30
W 0218 feed0818 36
W 0219 feed0919 44
W 021a feed0a1a 32
W 021b feed0b1b 38
W 021c feed0c1c 31
W 021d feed0d1d 41
W 021e feed0e1e 35
